//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = tb_exec_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
hw/cpu_pkg.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/id_exe.sv
hw/alu_exec.sv
hw/exec_core.sv
test/clock_gen.sv
test/exec_core_asserts.sv
test/tb_exec_core.sv

//--- hw/alu_exec.sv
`timescale 1ns/1ns

module alu_exec (
	input  logic             clk,
	input  logic             flush,
	input  logic [15:0]      op1,
	input  logic [15:0]      op2,
	input  cpu_pkg::alu_op_e alu_op,
	input  logic [15:0]      mem_write_value,
	input  logic             ex_mem_read,
	input  logic             ex_mem_write,
	input  logic             ex_reg_write,
	input  logic             ex_valid,
	input  logic [2:0]       ex_reg_addr,
	output logic [15:0]      result,
	output logic [15:0]      store_value,
	output logic             result_valid,
	output logic             reg_write,
	output logic             mem_read,
	output logic             mem_write,
	output logic [2:0]       dest,
	output logic             wr_en,
	output logic [2:0]       wr_addr,
	output logic [15:0]      wr_data
);
	import cpu_pkg::*;

	logic [15:0] alu_y;

	always_comb begin
		case (alu_op)
			ALU_ADD:  alu_y = op1 + op2; // Wraps at 16 bits
			ALU_SUB:  alu_y = op1 - op2;
			ALU_AND:  alu_y = op1 & op2;
			ALU_OR:   alu_y = op1 | op2;
			ALU_SLL:  alu_y = op1 << op2[3:0]; // Shift of 1 to 8
			default:  alu_y = op1; // PASS
		endcase
	end

	// Write-back lands on the same edge as the result register
	assign wr_en   = ex_reg_write & ex_valid;
	assign wr_addr = ex_reg_addr;
	assign wr_data = alu_y;

	always_ff @(posedge clk or posedge flush) begin
		if (flush) begin
			result_valid <= 1'b0;
			reg_write    <= 1'b0;
			mem_read     <= 1'b0;
			mem_write    <= 1'b0;
		end else begin
			result_valid <= ex_valid; // Single pulse
			if (ex_valid) begin
				reg_write <= ex_reg_write;
				mem_read  <= ex_mem_read;
				mem_write <= ex_mem_write;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			result      <= alu_y;
			dest        <= ex_reg_addr;
			store_value <= mem_write_value;
		end
	end

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Major opcodes, bits [15:11]

	localparam logic [4:0] OP_ADDIU = 5'b01001;
	localparam logic [4:0] OP_LI    = 5'b01101;
	localparam logic [4:0] OP_RRR   = 5'b11100; // ADDU, SUBU
	localparam logic [4:0] OP_ALU2  = 5'b11101; // AND, OR
	localparam logic [4:0] OP_SLL   = 5'b00110;
	localparam logic [4:0] OP_MOVE  = 5'b01111;
	localparam logic [4:0] OP_LW    = 5'b10011;
	localparam logic [4:0] OP_SW    = 5'b11011;
	localparam logic [4:0] OP_NOP   = 5'b00001;

	// Minor codes
	localparam logic [1:0] FN_ADDU = 2'b01; // funct field
	localparam logic [1:0] FN_SUBU = 2'b11;
	localparam logic [1:0] FN_SLL  = 2'b00;
	localparam logic [4:0] FN_AND  = 5'b01100; // Low five bits, rz and funct
	localparam logic [4:0] FN_OR   = 5'b01101;

	localparam logic [15:0] NOP_WORD = 16'h0800;

	//////////////////////////////////////////////////////////////////////
	// Instruction word views

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [7:0] imm8;
	} i_fmt_t;

	typedef struct packed {
		logic [4:0] opcode;
		logic [2:0] rx;
		logic [2:0] ry;
		logic [2:0] rz; // Also the SLL shift amount
		logic [1:0] funct;
	} r_fmt_t;

	typedef union packed {
		i_fmt_t i_fmt;
		r_fmt_t r_fmt;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLL,
		ALU_PASS
	} alu_op_e;

endpackage

//--- hw/exec_core.sv
`timescale 1ns/1ns

module exec_core (
	input  logic        clk,
	input  logic        flush,
	input  logic        req,
	input  logic [15:0] instr,
	output logic        ack,
	output logic [15:0] result,
	output logic        result_valid,
	output logic [2:0]  dest,
	output logic        reg_write,
	output logic        mem_read,
	output logic        mem_write,
	output logic [15:0] store_value
);
	import cpu_pkg::*;

	logic [2:0]  ra1;
	logic [2:0]  ra2;
	logic [15:0] rd1;
	logic [15:0] rd2;
	instr_u      opn;
	logic [15:0] read_value1;
	logic [15:0] read_value2;
	logic        dec_mem_read;
	logic        dec_mem_write;
	logic        dec_reg_write;
	logic        dec_valid;
	logic [2:0]  dec_reg_addr;

	logic [15:0] op1;
	logic [15:0] op2;
	logic [15:0] mem_write_value;
	alu_op_e     alu_op;
	logic        ex_mem_read;
	logic        ex_mem_write;
	logic        ex_reg_write;
	logic        ex_valid;
	logic [2:0]  ex_reg_addr;

	logic        wr_en;
	logic [2:0]  wr_addr;
	logic [15:0] wr_data;

	//////////////////////////////////////////////////////////////////////
	// Decode, register file, ID/EX and execute

	inst_decode inst_decode_inst (
		.clk         (clk),
		.flush       (flush),
		.req         (req),
		.instr       (instr),
		.ack         (ack),
		.ra1         (ra1),
		.ra2         (ra2),
		.rd1         (rd1),
		.rd2         (rd2),
		.opn         (opn),
		.read_value1 (read_value1),
		.read_value2 (read_value2),
		.mem_read    (dec_mem_read),
		.mem_write   (dec_mem_write),
		.reg_write   (dec_reg_write),
		.valid       (dec_valid),
		.reg_addr    (dec_reg_addr)
	);

	reg_file reg_file_inst (
		.clk     (clk),
		.flush   (flush),
		.ra1     (ra1),
		.ra2     (ra2),
		.wr_addr (wr_addr),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.rd1     (rd1),
		.rd2     (rd2)
	);

	id_exe id_exe_inst (
		.clk             (clk),
		.flush           (flush),
		.opn             (opn),
		.read_value1     (read_value1),
		.read_value2     (read_value2),
		.mem_read        (dec_mem_read),
		.mem_write       (dec_mem_write),
		.reg_write       (dec_reg_write),
		.valid           (dec_valid),
		.reg_addr        (dec_reg_addr),
		.op1             (op1),
		.op2             (op2),
		.mem_write_value (mem_write_value),
		.alu_op          (alu_op),
		.mem_read_out    (ex_mem_read),
		.mem_write_out   (ex_mem_write),
		.reg_write_out   (ex_reg_write),
		.valid_out       (ex_valid),
		.reg_addr_out    (ex_reg_addr)
	);

	alu_exec alu_exec_inst (
		.clk             (clk),
		.flush           (flush),
		.op1             (op1),
		.op2             (op2),
		.alu_op          (alu_op),
		.mem_write_value (mem_write_value),
		.ex_mem_read     (ex_mem_read),
		.ex_mem_write    (ex_mem_write),
		.ex_reg_write    (ex_reg_write),
		.ex_valid        (ex_valid),
		.ex_reg_addr     (ex_reg_addr),
		.result          (result),
		.store_value     (store_value),
		.result_valid    (result_valid),
		.reg_write       (reg_write),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.dest            (dest),
		.wr_en           (wr_en),
		.wr_addr         (wr_addr),
		.wr_data         (wr_data)
	);

endmodule

//--- hw/id_exe.sv
`timescale 1ns/1ns

module id_exe (
	input  logic             clk,
	input  logic             flush,
	input  cpu_pkg::instr_u  opn,
	input  logic [15:0]      read_value1,
	input  logic [15:0]      read_value2,
	input  logic             mem_read,
	input  logic             mem_write,
	input  logic             reg_write,
	input  logic             valid,
	input  logic [2:0]       reg_addr,
	output logic [15:0]      op1,
	output logic [15:0]      op2,
	output logic [15:0]      mem_write_value,
	output cpu_pkg::alu_op_e alu_op,
	output logic             mem_read_out,
	output logic             mem_write_out,
	output logic             reg_write_out,
	output logic             valid_out,
	output logic [2:0]       reg_addr_out
);
	import cpu_pkg::*;

	instr_u      opn_q; // ID/EX instruction word
	logic [15:0] imm_sext;
	logic [15:0] imm_zext;
	logic [15:0] shamt;

	assign imm_sext = {{8{opn.i_fmt.imm8[7]}}, opn.i_fmt.imm8};
	assign imm_zext = {8'h00, opn.i_fmt.imm8};
	assign shamt    = (opn.r_fmt.rz == 3'd0) ? 16'd8 : {13'd0, opn.r_fmt.rz}; // 0 encodes 8

	//////////////////////////////////////////////////////////////////////
	// Pipeline register and operand selection

	always_ff @(posedge clk or posedge flush) begin
		if (flush) begin
			opn_q           <= NOP_WORD;
			op1             <= 16'h0000;
			op2             <= 16'h0000;
			mem_write_value <= 16'h0000;
			mem_read_out    <= 1'b0;
			mem_write_out   <= 1'b0;
			reg_write_out   <= 1'b0;
			valid_out       <= 1'b0;
			reg_addr_out    <= 3'd0;
		end else begin
			opn_q           <= opn;
			mem_read_out    <= mem_read;
			mem_write_out   <= mem_write;
			reg_write_out   <= reg_write;
			valid_out       <= valid;
			reg_addr_out    <= reg_addr;
			op1             <= 16'h0000;
			op2             <= 16'h0000;
			mem_write_value <= 16'h0000;
			case (opn.i_fmt.opcode)
				OP_ADDIU, OP_LW: begin
					op1 <= read_value1;
					op2 <= imm_sext;
				end
				OP_SW: begin
					op1             <= read_value1; // Base plus offset
					op2             <= imm_sext;
					mem_write_value <= read_value2;
				end
				OP_LI:  op1 <= imm_zext;
				OP_RRR, OP_ALU2: begin
					op1 <= read_value1;
					op2 <= read_value2;
				end
				OP_SLL: begin
					op1 <= read_value2; // ry is shifted
					op2 <= shamt;
				end
				OP_MOVE: op1 <= read_value2;
				default: ; // NOP and unknown keep zero operands
			endcase
		end
	end

	// ALU function follows the latched word
	always_comb begin
		alu_op = ALU_PASS;
		case (opn_q.r_fmt.opcode)
			OP_ADDIU, OP_LW, OP_SW: alu_op = ALU_ADD;
			OP_RRR: begin
				if (opn_q.r_fmt.funct == FN_ADDU)
					alu_op = ALU_ADD;
				else if (opn_q.r_fmt.funct == FN_SUBU)
					alu_op = ALU_SUB;
			end
			OP_ALU2: begin
				if ({opn_q.r_fmt.rz, opn_q.r_fmt.funct} == FN_AND)
					alu_op = ALU_AND;
				else if ({opn_q.r_fmt.rz, opn_q.r_fmt.funct} == FN_OR)
					alu_op = ALU_OR;
			end
			OP_SLL:  if (opn_q.r_fmt.funct == FN_SLL) alu_op = ALU_SLL;
			default: ;
		endcase
	end

endmodule

//--- hw/inst_decode.sv
`timescale 1ns/1ns

module inst_decode (
	input  logic            clk,
	input  logic            flush,
	input  logic            req,
	input  logic [15:0]     instr,
	output logic            ack,
	output logic [2:0]      ra1,
	output logic [2:0]      ra2,
	input  logic [15:0]     rd1,
	input  logic [15:0]     rd2,
	output cpu_pkg::instr_u opn,
	output logic [15:0]     read_value1,
	output logic [15:0]     read_value2,
	output logic            mem_read,
	output logic            mem_write,
	output logic            reg_write,
	output logic            valid,
	output logic [2:0]      reg_addr
);
	import cpu_pkg::*;

	logic accept;

	assign accept = req & ~ack; // The edge E

	//////////////////////////////////////////////////////////////////////
	// Four-phase handshake and instruction register

	always_ff @(posedge clk or posedge flush) begin
		if (flush) begin
			ack   <= 1'b0;
			valid <= 1'b0;
			opn   <= NOP_WORD;
		end else begin
			valid <= accept; // One-cycle pulse
			if (accept) begin
				ack <= 1'b1;
				opn <= instr;
			end else if (!req) begin
				ack <= 1'b0; // Return to idle
			end
		end
	end

	// Register port addresses
	always_comb begin
		ra1 = opn.i_fmt.rx; // Base or first source
		ra2 = opn.r_fmt.ry; // ry also carries the SW store data
		case (opn.i_fmt.opcode)
			OP_ADDIU, OP_LI, OP_LW: ra2 = 3'd0; // Second port unused
			default: ;
		endcase
	end

	assign read_value1 = rd1;
	assign read_value2 = rd2;

	// Control decode, unknown opcodes raise nothing
	always_comb begin
		mem_read  = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		reg_addr  = opn.r_fmt.rx;
		case (opn.r_fmt.opcode)
			OP_ADDIU, OP_LI: reg_write = 1'b1;
			OP_RRR: begin
				reg_write = (opn.r_fmt.funct == FN_ADDU) || (opn.r_fmt.funct == FN_SUBU);
				reg_addr  = opn.r_fmt.rz; // Three-register form
			end
			OP_ALU2: reg_write = ({opn.r_fmt.rz, opn.r_fmt.funct} == FN_AND) ||
				({opn.r_fmt.rz, opn.r_fmt.funct} == FN_OR);
			OP_SLL:  reg_write = (opn.r_fmt.funct == FN_SLL);
			OP_MOVE: reg_write = ({opn.r_fmt.rz, opn.r_fmt.funct} == 5'b00000);
			OP_LW:   mem_read  = 1'b1; // Address only
			OP_SW:   mem_write = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
	input  logic        clk,
	input  logic        flush,
	input  logic [2:0]  ra1,
	input  logic [2:0]  ra2,
	input  logic [2:0]  wr_addr,
	input  logic        wr_en,
	input  logic [15:0] wr_data,
	output logic [15:0] rd1,
	output logic [15:0] rd2
);

	logic [15:0] regs [8]; // R0..R7, no hardwired zero

	always_ff @(posedge clk or posedge flush) begin
		if (flush) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= 16'h0000;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Reads are combinational
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

endmodule

//--- test/clock_gen.sv
`timescale 1ns/1ns

module clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk; // 50 ns high, 50 ns low

endmodule

//--- test/exec_core_asserts.sv
`timescale 1ns/1ns

module exec_core_asserts (
	input logic clk,
	input logic flush,
	input logic req,
	input logic ack,
	input logic result_valid,
	input logic mem_read,
	input logic mem_write
);

	// Single-cycle result pulse
	assert property (@(posedge clk) disable iff (flush) result_valid |=> !result_valid)
		else $error("result_valid stayed high for two cycles");

	// ack only answers a pending req
	assert property (@(posedge clk) disable iff (flush) $rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	assert property (@(posedge clk) disable iff (flush) !(mem_read && mem_write))
		else $error("mem_read and mem_write high together");

endmodule

bind exec_core exec_core_asserts exec_core_asserts_inst (
	.clk          (clk),
	.flush        (flush),
	.req          (req),
	.ack          (ack),
	.result_valid (result_valid),
	.mem_read     (mem_read),
	.mem_write    (mem_write)
);

//--- test/exec_patterns.hex
// First word is the record count in hex, then one record per line
// instr result dest reg_write mem_read mem_write store_value
0019
E14D 0000 3 1 0 0 0000
697F 007F 1 1 0 0 0000
4985 0004 1 1 0 0 0000
6AFF 00FF 2 1 0 0 0000
4A7F 017E 2 1 0 0 0000
4CFF FFFF 4 1 0 0 0000
4C03 0002 4 1 0 0 0000
6DC3 00C3 5 1 0 0 0000
6E5A 005A 6 1 0 0 0000
E5DD 011D 7 1 0 0 0000
E6AF FF97 3 1 0 0 0000
EDCC 0042 5 1 0 0 0000
EE6D FFDF 6 1 0 0 0000
3144 02FC 1 1 0 0 0000
34EC 08E8 4 1 0 0 0000
32BC 2100 2 1 0 0 0000
3760 9700 7 1 0 0 0000
35D4 FBE0 5 1 0 0 0000
7B20 02FC 3 1 0 0 0000
9AF0 20F0 2 0 1 0 0000
DC24 090C 4 0 0 1 02FC
0800 0000 0 0 0 0 0000
FE12 0000 6 0 0 0 0000
78C0 FFDF 0 1 0 0 0000
7F40 2100 7 1 0 0 0000

//--- test/tb_exec_core.sv
`timescale 1ns/1ns

module tb_exec_core;

	localparam int          CLK_PERIOD   = 100;
	localparam int          FLUSH_CYCLES = 16;
	localparam int          MAX_RECS     = 64;
	localparam int          REC_WORDS    = 7; // instr, result, dest, three flags, store
	localparam int          PAT_WORDS    = 1 + MAX_RECS * REC_WORDS;
	localparam int          RV_LATENCY   = 2; // Result registered at E+2
	localparam logic [31:0] SEED         = 32'h2d46_fb36;

	logic        clk;
	logic        flush;
	logic        req;
	logic [15:0] instr;
	logic        ack;
	logic [15:0] result;
	logic        result_valid;
	logic [2:0]  dest;
	logic        reg_write;
	logic        mem_read;
	logic        mem_write;
	logic [15:0] store_value;

	logic [15:0] pat_mem [0:PAT_WORDS-1];
	int          num_recs;
	int          cycle_limit = 0;
	int          edge_count  = 0;

	clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen_inst (.clk(clk));

	exec_core exec_core_inst (
		.clk          (clk),
		.flush        (flush),
		.req          (req),
		.instr        (instr),
		.ack          (ack),
		.result       (result),
		.result_valid (result_valid),
		.dest         (dest),
		.reg_write    (reg_write),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.store_value  (store_value)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic compare_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Edge counter doubles as the watchdog
	always @(posedge clk) begin
		edge_count <= edge_count + 1;
		if (cycle_limit > 0 && edge_count >= cycle_limit) begin
			fail_run("Timeout: the run went past its cycle limit without finishing");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// One four-phase transfer and the check of its result

	task automatic issue_record(input int rec);
		int          base;
		int          gap;
		int          accept_edge;
		logic [15:0] word;
		base = 1 + rec * REC_WORDS;
		word = pat_mem[base];
		gap  = $urandom_range(3, 0);
		repeat (gap) @(negedge clk);
		while (ack) @(negedge clk); // New req only after ack is low
		req   = 1'b1;
		instr = word;
		@(negedge clk);
		while (!ack) @(negedge clk);
		accept_edge = edge_count;
		req = 1'b0;
		while (!result_valid) @(negedge clk);
		compare_value("result_valid latency", 16'(edge_count - accept_edge), 16'(RV_LATENCY));
		compare_value("result", result, pat_mem[base + 1]);
		compare_value("dest", {13'd0, dest}, pat_mem[base + 2]);
		compare_value("reg_write", {15'd0, reg_write}, pat_mem[base + 3]);
		compare_value("mem_read", {15'd0, mem_read}, pat_mem[base + 4]);
		compare_value("mem_write", {15'd0, mem_write}, pat_mem[base + 5]);
		compare_value("store_value", store_value, pat_mem[base + 6]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int unsigned seed_ret;
		flush = 1'b1;
		req   = 1'b0;
		instr = 16'h0000;
		for (int i = 0; i < PAT_WORDS; i++) begin
			pat_mem[i] = ~16'(i);
		end
		$readmemh("test/exec_patterns.hex", pat_mem);
		num_recs = int'(pat_mem[0]);
		if (num_recs < 1 || num_recs > MAX_RECS) begin
			fail_run("Pattern file missing or its record count is out of range");
		end
		cycle_limit = num_recs * 12 + 40;
		seed_ret = $urandom(SEED);

		repeat (FLUSH_CYCLES) @(negedge clk);
		flush = 1'b0;
		@(negedge clk);
		compare_value("ack", {15'd0, ack}, 16'h0000); // Idle state after flush
		compare_value("result_valid", {15'd0, result_valid}, 16'h0000);
		compare_value("reg_write", {15'd0, reg_write}, 16'h0000);
		compare_value("mem_read", {15'd0, mem_read}, 16'h0000);
		compare_value("mem_write", {15'd0, mem_write}, 16'h0000);

		for (int r = 0; r < num_recs; r++) begin
			issue_record(r);
		end
		repeat (2) @(negedge clk);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
